/* files.f */
src/core_pkg.sv
src/ex_ctrl_pkg.sv
src/alu.sv
src/flag_reg.sv
src/branch_unit.sv
src/forward_unit.sv
src/ex_stage.sv
src/ex_top.sv
+incdir+bench
bench/ex_tb.sv

/* run.sh */
#!/bin/sh
# Builds the execute stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
	--top-module ex_tb -Mdir obj_dir -f files.f
status=$?
if [ "$status" -ne 0 ]; then
	echo "run.sh: Verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vex_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "run.sh: simulation ended with status $status"
	exit "$status"
fi

exit 0

/* bench/ex_model.svh */
`ifndef ex_model_svh
`define ex_model_svh

typedef logic [core_pkg::gpr_width-1:0] word_t;
typedef logic [core_pkg::pc_width-1:0] pc_t;
typedef logic [ex_ctrl_pkg::flag_width-1:0] flags_t;

// Expected ALU result, straight from the function table
function automatic word_t ref_alu_result(input word_t a, input word_t b,
		input ex_ctrl_pkg::alu_funct_t f);
	int unsigned sh;
	word_t r;
	sh = b % core_pkg::gpr_width; // Shift amount wraps at the word width
	case (f)
		ex_ctrl_pkg::alu_add: r = a + b;
		ex_ctrl_pkg::alu_sub: r = a - b;
		ex_ctrl_pkg::alu_and: r = a & b;
		ex_ctrl_pkg::alu_or: r = a | b;
		ex_ctrl_pkg::alu_xor: r = a ^ b;
		ex_ctrl_pkg::alu_nor: r = ~(a | b);
		ex_ctrl_pkg::alu_sll: r = a << sh;
		ex_ctrl_pkg::alu_srl: r = a >> sh;
		ex_ctrl_pkg::alu_slt: r = ($signed(a) < $signed(b)) ? word_t'(1) : '0;
		ex_ctrl_pkg::alu_pass_b: r = b;
		default: r = '0; // Undefined codes
	endcase
	return r;
endfunction

// Expected flag vector for a flag-writing instruction
function automatic flags_t ref_flags(input word_t a, input word_t b,
		input ex_ctrl_pkg::alu_funct_t f);
	word_t r;
	logic signed [core_pkg::gpr_width:0] exact; // Signed result one bit wider, never wraps
	logic sa;
	logic sb;
	flags_t fl;
	r = ref_alu_result(a, b, f);
	sa = a[core_pkg::gpr_width-1];
	sb = b[core_pkg::gpr_width-1];
	fl = '0;
	fl[ex_ctrl_pkg::flag_zero] = (r == '0);
	fl[ex_ctrl_pkg::flag_neg] = r[core_pkg::gpr_width-1];
	fl[ex_ctrl_pkg::flag_true] = 1'b1; // Every write sets it
	if (f == ex_ctrl_pkg::alu_add) begin
		exact = $signed({sa, a}) + $signed({sb, b});
		fl[ex_ctrl_pkg::flag_carry] = (r < a); // Unsigned sum wrapped around
		// Overflow when the exact sum does not fit in a word
		fl[ex_ctrl_pkg::flag_ovf] = (exact[core_pkg::gpr_width] != exact[core_pkg::gpr_width-1]);
	end else if (f == ex_ctrl_pkg::alu_sub) begin
		exact = $signed({sa, a}) - $signed({sb, b});
		fl[ex_ctrl_pkg::flag_carry] = (a < b); // Borrow
		fl[ex_ctrl_pkg::flag_ovf] = (exact[core_pkg::gpr_width] != exact[core_pkg::gpr_width-1]);
	end
	return fl;
endfunction

// Branch decision against the committed flags
function automatic logic ref_taken(input logic br, input logic jflag, input logic bne,
		input logic jf, input core_pkg::reg_addr_t code, input flags_t fl);
	logic bit_val;
	logic known;
	logic tk;
	bit_val = 1'b0;
	known = 1'b0;
	for (int i = 0; i < ex_ctrl_pkg::flag_width; i++) begin
		if (code == core_pkg::reg_addr_t'(i)) begin
			bit_val = fl[i];
			known = 1'b1;
		end
	end
	if (!br) begin
		tk = 1'b0;
	end else if (!jflag) begin
		tk = bne ? !fl[ex_ctrl_pkg::flag_zero] : fl[ex_ctrl_pkg::flag_zero];
	end else begin
		tk = known && (jf ? !bit_val : bit_val); // Codes above 4 never jump
	end
	return tk;
endfunction

// Forward select, EX/MEM first, register 0 never
function automatic ex_ctrl_pkg::fwd_sel_t ref_fwd(input core_pkg::reg_addr_t src,
		input core_pkg::reg_addr_t exd, input logic exw,
		input core_pkg::reg_addr_t wbd, input logic wbw);
	ex_ctrl_pkg::fwd_sel_t sel;
	sel = ex_ctrl_pkg::fwd_none;
	if (src != core_pkg::zero_reg && exw && exd == src) begin
		sel = ex_ctrl_pkg::fwd_ex;
	end else if (src != core_pkg::zero_reg && wbw && wbd == src) begin
		sel = ex_ctrl_pkg::fwd_mem;
	end
	return sel;
endfunction

function automatic core_pkg::reg_addr_t ref_dest(input ex_ctrl_pkg::reg_dst_t sel,
		input core_pkg::reg_addr_t rt_f, input core_pkg::reg_addr_t rd_f);
	core_pkg::reg_addr_t d;
	case (sel)
		ex_ctrl_pkg::dst_rd: d = rd_f;
		ex_ctrl_pkg::dst_rt: d = rt_f;
		ex_ctrl_pkg::dst_link: d = core_pkg::link_reg;
		default: d = core_pkg::zero_reg;
	endcase
	return d;
endfunction

`endif

/* bench/ex_tb.sv */
`timescale 1ns/1ps

module ex_tb;

	localparam int dw = core_pkg::gpr_width;
	localparam int pw = core_pkg::pc_width;
	localparam int reset_wait_limit = 20; // Cycles allowed for reset release

	`include "ex_model.svh"

	logic clk;
	logic rst;
	ex_ctrl_pkg::alu_funct_t alu_funct;
	logic alu_src;
	ex_ctrl_pkg::reg_dst_t reg_dst;
	logic fl_write_enable;
	logic mem_write_enable;
	logic is_branch;
	logic sel_jflag_branch;
	logic sel_beq_bne;
	logic sel_jt_jf;
	logic [1:0] wb_res_mux;
	logic reg_write_enable;
	core_pkg::reg_addr_t rs;
	core_pkg::reg_addr_t rt;
	core_pkg::reg_addr_t rd;
	word_t data_rs;
	word_t data_rt;
	word_t imm;
	pc_t next_pc;
	word_t mem_wb_data;
	core_pkg::reg_addr_t mem_wb_dest;
	logic mem_wb_write;

	logic out_mem_write_enable;
	logic [1:0] out_wb_res_mux;
	logic out_reg_write_enable;
	word_t out_imm;
	pc_t out_next_pc;
	pc_t out_branch_addr;
	word_t out_alu_res;
	word_t out_mem_addr;
	word_t out_mem_data;
	core_pkg::reg_addr_t out_reg_dest;
	logic branch_taken;

	// Model copies of the stage state
	flags_t mdl_flags;
	core_pkg::reg_addr_t exm_dest;
	logic exm_write;
	word_t exm_res;
	logic br_pend; // Taken branch sitting in EX/MEM

	// Expected EX/MEM contents after the last edge
	logic exp_mem_we;
	logic [1:0] exp_wb_mux;
	logic exp_reg_we;
	word_t exp_imm;
	pc_t exp_next_pc;
	pc_t exp_branch_addr;
	word_t exp_alu_res;
	word_t exp_mem_addr;
	word_t exp_mem_data;
	core_pkg::reg_addr_t exp_reg_dest;
	logic exp_taken;
	logic chk_valid;
	int cycles;

	ex_top #(
		.data_width(dw),
		.pc_width(pw)
	) u_dut (
		.clk(clk),
		.rst(rst),
		.alu_funct(alu_funct),
		.alu_src(alu_src),
		.reg_dst(reg_dst),
		.fl_write_enable(fl_write_enable),
		.mem_write_enable(mem_write_enable),
		.is_branch(is_branch),
		.sel_jflag_branch(sel_jflag_branch),
		.sel_beq_bne(sel_beq_bne),
		.sel_jt_jf(sel_jt_jf),
		.wb_res_mux(wb_res_mux),
		.reg_write_enable(reg_write_enable),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.data_rs(data_rs),
		.data_rt(data_rt),
		.imm(imm),
		.next_pc(next_pc),
		.mem_wb_data(mem_wb_data),
		.mem_wb_dest(mem_wb_dest),
		.mem_wb_write(mem_wb_write),
		.out_mem_write_enable(out_mem_write_enable),
		.out_wb_res_mux(out_wb_res_mux),
		.out_reg_write_enable(out_reg_write_enable),
		.out_imm(out_imm),
		.out_next_pc(out_next_pc),
		.out_branch_addr(out_branch_addr),
		.out_alu_res(out_alu_res),
		.out_mem_addr(out_mem_addr),
		.out_mem_data(out_mem_data),
		.out_reg_dest(out_reg_dest),
		.branch_taken(branch_taken)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 ns period

	initial begin
		rst = 1'b1;
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b0;
	end

	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Result: FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_pc(input string name, input pc_t got, input pc_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_reg(input string name, input core_pkg::reg_addr_t got,
			input core_pkg::reg_addr_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_mux(input string name, input logic [1:0] got, input logic [1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// Outputs settle at the rising edge, compare half a cycle later
	always @(negedge clk) begin
		if (chk_valid) begin
			check_word("out_alu_res", out_alu_res, exp_alu_res);
			check_word("out_mem_addr", out_mem_addr, exp_mem_addr);
			check_word("out_mem_data", out_mem_data, exp_mem_data);
			check_word("out_imm", out_imm, exp_imm);
			check_pc("out_next_pc", out_next_pc, exp_next_pc);
			check_pc("out_branch_addr", out_branch_addr, exp_branch_addr);
			check_reg("out_reg_dest", out_reg_dest, exp_reg_dest);
			check_mux("out_wb_res_mux", out_wb_res_mux, exp_wb_mux);
			check_bit("out_mem_write_enable", out_mem_write_enable, exp_mem_we);
			check_bit("out_reg_write_enable", out_reg_write_enable, exp_reg_we);
			check_bit("branch_taken", branch_taken, exp_taken);
		end
	end

	function automatic word_t forwarded_value(input ex_ctrl_pkg::fwd_sel_t sel, input word_t rf);
		word_t v;
		v = rf;
		if (sel == ex_ctrl_pkg::fwd_ex) begin
			v = exm_res;
		end else if (sel == ex_ctrl_pkg::fwd_mem) begin
			v = mem_wb_data;
		end
		return v;
	endfunction

	// Random non-branch instruction, MEM/WB idle
	task automatic randomize_instr();
		alu_funct = ex_ctrl_pkg::alu_funct_t'($urandom_range(0, 11)); // Two undefined codes too
		alu_src = 1'($urandom);
		reg_dst = ex_ctrl_pkg::reg_dst_t'($urandom);
		fl_write_enable = 1'($urandom);
		mem_write_enable = 1'($urandom);
		reg_write_enable = 1'($urandom);
		wb_res_mux = 2'($urandom);
		is_branch = 1'b0;
		sel_jflag_branch = 1'($urandom);
		sel_beq_bne = 1'($urandom);
		sel_jt_jf = 1'($urandom);
		rs = core_pkg::reg_addr_t'($urandom);
		rt = core_pkg::reg_addr_t'($urandom);
		rd = core_pkg::reg_addr_t'($urandom);
		data_rs = word_t'($urandom);
		data_rt = word_t'($urandom);
		imm = word_t'($urandom);
		next_pc = pc_t'($urandom);
		mem_wb_data = word_t'($urandom);
		mem_wb_dest = core_pkg::reg_addr_t'($urandom);
		mem_wb_write = 1'b0;
	endtask

	// Predict the current instruction, let one edge pass, then commit the model
	task automatic step();
		ex_ctrl_pkg::fwd_sel_t fa;
		ex_ctrl_pkg::fwd_sel_t fb;
		word_t a_val;
		word_t b_val;
		word_t op2;
		logic tk;
		fa = ref_fwd(rs, exm_dest, exm_write, mem_wb_dest, mem_wb_write);
		fb = ref_fwd(rt, exm_dest, exm_write, mem_wb_dest, mem_wb_write);
		a_val = forwarded_value(fa, data_rs);
		b_val = forwarded_value(fb, data_rt);
		op2 = (alu_src == ex_ctrl_pkg::alu_src_imm) ? imm : b_val;
		tk = ref_taken(is_branch, sel_jflag_branch, sel_beq_bne, sel_jt_jf, rs, mdl_flags);
		@(posedge clk);
		if (br_pend) begin
			exp_alu_res = '0; // Squashed slot
			exp_mem_addr = '0;
			exp_mem_data = '0;
			exp_imm = '0;
			exp_next_pc = '0;
			exp_branch_addr = '0;
			exp_reg_dest = '0;
			exp_wb_mux = '0;
			exp_mem_we = 1'b0;
			exp_reg_we = 1'b0;
			exp_taken = 1'b0;
		end else begin
			exp_alu_res = ref_alu_result(a_val, op2, alu_funct);
			exp_mem_addr = a_val;
			exp_mem_data = b_val; // Store data ignores the immediate
			exp_imm = imm;
			exp_next_pc = next_pc;
			exp_branch_addr = next_pc + imm[pw-1:0];
			exp_reg_dest = ref_dest(reg_dst, rt, rd);
			exp_wb_mux = wb_res_mux;
			exp_mem_we = mem_write_enable;
			exp_reg_we = reg_write_enable;
			exp_taken = tk;
			if (fl_write_enable) begin
				mdl_flags = ref_flags(a_val, op2, alu_funct);
			end
		end
		exm_dest = exp_reg_dest;
		exm_write = exp_reg_we;
		exm_res = exp_alu_res;
		br_pend = exp_taken;
		chk_valid = 1'b1;
		#2;
	endtask

	initial begin
		void'($urandom(32'hd09974e7));
		alu_funct = '0;
		alu_src = 1'b0;
		reg_dst = '0;
		fl_write_enable = 1'b0;
		mem_write_enable = 1'b0;
		is_branch = 1'b0;
		sel_jflag_branch = 1'b0;
		sel_beq_bne = 1'b0;
		sel_jt_jf = 1'b0;
		wb_res_mux = '0;
		reg_write_enable = 1'b0;
		rs = '0;
		rt = '0;
		rd = '0;
		data_rs = '0;
		data_rt = '0;
		imm = '0;
		next_pc = '0;
		mem_wb_data = '0;
		mem_wb_dest = '0;
		mem_wb_write = 1'b0;
		mdl_flags = '0;
		exm_dest = '0;
		exm_write = 1'b0;
		exm_res = '0;
		br_pend = 1'b0;
		exp_alu_res = '0; // Everything reads zero out of reset
		exp_mem_addr = '0;
		exp_mem_data = '0;
		exp_imm = '0;
		exp_next_pc = '0;
		exp_branch_addr = '0;
		exp_reg_dest = '0;
		exp_wb_mux = '0;
		exp_mem_we = 1'b0;
		exp_reg_we = 1'b0;
		exp_taken = 1'b0;
		chk_valid = 1'b0;
		cycles = 0;

		@(posedge clk);
		#2;
		chk_valid = 1'b1;
		while (rst !== 1'b0) begin
			if (cycles >= reset_wait_limit) begin
				stop_on_error("Reset was never released");
			end else begin
				@(posedge clk);
				cycles++;
			end
		end
		#2;

		// Random ALU traffic, no MEM/WB forwarding
		repeat (200) begin
			randomize_instr();
			step();
		end

		// Dependent pair through EX/MEM
		randomize_instr();
		rd = 4'd5;
		reg_dst = ex_ctrl_pkg::dst_rd;
		reg_write_enable = 1'b1;
		step();
		randomize_instr();
		rs = 4'd5;
		rt = 4'd5;
		step();

		// MEM/WB match only
		randomize_instr();
		reg_write_enable = 1'b0;
		step();
		randomize_instr();
		rs = 4'd7;
		rt = 4'd3;
		mem_wb_write = 1'b1;
		mem_wb_dest = 4'd7;
		step();

		// Both stages match, EX/MEM must win
		randomize_instr();
		rd = 4'd9;
		reg_dst = ex_ctrl_pkg::dst_rd;
		reg_write_enable = 1'b1;
		step();
		randomize_instr();
		rs = 4'd9;
		rt = 4'd9;
		mem_wb_write = 1'b1;
		mem_wb_dest = 4'd9;
		step();

		// Register 0 written everywhere but never forwarded
		randomize_instr();
		rd = '0;
		reg_dst = ex_ctrl_pkg::dst_rd;
		reg_write_enable = 1'b1;
		step();
		randomize_instr();
		rs = '0;
		rt = '0;
		mem_wb_write = 1'b1;
		mem_wb_dest = '0;
		step();

		// Dense hazards over a few registers
		repeat (100) begin
			randomize_instr();
			rs = core_pkg::reg_addr_t'($urandom_range(0, 3));
			rt = core_pkg::reg_addr_t'($urandom_range(0, 3));
			rd = core_pkg::reg_addr_t'($urandom_range(0, 3));
			mem_wb_dest = core_pkg::reg_addr_t'($urandom_range(0, 3));
			mem_wb_write = 1'($urandom);
			step();
		end

		// Flag writes mixed with beq, bne, jt and jf
		repeat (150) begin
			randomize_instr();
			if ($urandom_range(0, 3) == 0) begin
				data_rt = data_rs; // Zero results now and then
			end
			is_branch = ($urandom_range(0, 2) == 0);
			rs = core_pkg::reg_addr_t'($urandom_range(0, 7)); // Flag codes past 4 too
			step();
		end

		// Squash of a flag writer behind a taken beq
		randomize_instr();
		step();
		randomize_instr();
		alu_funct = ex_ctrl_pkg::alu_sub;
		alu_src = ex_ctrl_pkg::alu_src_reg;
		rs = '0;
		rt = '0;
		data_rt = data_rs;
		fl_write_enable = 1'b1; // Zero flag set
		step();
		randomize_instr();
		is_branch = 1'b1;
		sel_jflag_branch = 1'b0;
		sel_beq_bne = 1'b0;
		fl_write_enable = 1'b0; // Keep the zero flag for the later jt
		step();
		if (!br_pend) begin
			stop_on_error("Directed beq did not resolve as taken");
		end
		randomize_instr();
		alu_funct = ex_ctrl_pkg::alu_or;
		alu_src = ex_ctrl_pkg::alu_src_imm;
		imm = word_t'(1); // Would clear the zero flag if it landed
		fl_write_enable = 1'b1;
		reg_write_enable = 1'b1;
		mem_write_enable = 1'b1;
		wb_res_mux = 2'd3;
		step();
		randomize_instr();
		is_branch = 1'b1;
		sel_jflag_branch = 1'b1;
		sel_jt_jf = 1'b0;
		rs = core_pkg::reg_addr_t'(ex_ctrl_pkg::flag_zero); // jt on zero
		step();
		if (!br_pend) begin
			stop_on_error("Flag jump after the squashed flag write was not taken");
		end
		randomize_instr();
		step();
		randomize_instr();
		step();

		@(negedge clk);
		#1;
		$display("Result: PASSED");
		$finish;
	end

endmodule

/* src/ex_top.sv */
`timescale 1ns/1ps

module ex_top #(
	parameter int data_width = core_pkg::gpr_width,
	parameter int pc_width = core_pkg::pc_width
) (
	input  logic                    clk,
	input  logic                    rst,
	input  ex_ctrl_pkg::alu_funct_t alu_funct,
	input  logic                    alu_src,
	input  ex_ctrl_pkg::reg_dst_t   reg_dst,
	input  logic                    fl_write_enable,
	input  logic                    mem_write_enable,
	input  logic                    is_branch,
	input  logic                    sel_jflag_branch,
	input  logic                    sel_beq_bne,
	input  logic                    sel_jt_jf,
	input  logic [1:0]              wb_res_mux,
	input  logic                    reg_write_enable,
	input  core_pkg::reg_addr_t     rs,
	input  core_pkg::reg_addr_t     rt,
	input  core_pkg::reg_addr_t     rd,
	input  logic [data_width-1:0]   data_rs,
	input  logic [data_width-1:0]   data_rt,
	input  logic [data_width-1:0]   imm,
	input  logic [pc_width-1:0]     next_pc,
	input  logic [data_width-1:0]   mem_wb_data,  // Value being written back this cycle
	input  core_pkg::reg_addr_t     mem_wb_dest,
	input  logic                    mem_wb_write,
	output logic                    out_mem_write_enable,
	output logic [1:0]              out_wb_res_mux,
	output logic                    out_reg_write_enable,
	output logic [data_width-1:0]   out_imm,
	output logic [pc_width-1:0]     out_next_pc,
	output logic [pc_width-1:0]     out_branch_addr,
	output logic [data_width-1:0]   out_alu_res,
	output logic [data_width-1:0]   out_mem_addr,
	output logic [data_width-1:0]   out_mem_data,
	output core_pkg::reg_addr_t     out_reg_dest,
	output logic                    branch_taken
);

	ex_ctrl_pkg::fwd_sel_t forward_a;
	ex_ctrl_pkg::fwd_sel_t forward_b;

	// EX/MEM side of the hazard check comes from the stage's own register
	forward_unit u_fwd (
		.rs(rs),
		.rt(rt),
		.ex_mem_dest(out_reg_dest),
		.ex_mem_write(out_reg_write_enable),
		.mem_wb_dest(mem_wb_dest),
		.mem_wb_write(mem_wb_write),
		.forward_a(forward_a),
		.forward_b(forward_b)
	);

	ex_stage #(
		.data_width(data_width),
		.pc_width(pc_width)
	) u_ex (
		.clk(clk),
		.rst(rst),
		.alu_funct(alu_funct),
		.alu_src(alu_src),
		.reg_dst(reg_dst),
		.fl_write_enable(fl_write_enable),
		.mem_write_enable(mem_write_enable),
		.is_branch(is_branch),
		.sel_jflag_branch(sel_jflag_branch),
		.sel_beq_bne(sel_beq_bne),
		.sel_jt_jf(sel_jt_jf),
		.wb_res_mux(wb_res_mux),
		.reg_write_enable(reg_write_enable),
		.rs(rs),
		.rt(rt),
		.rd(rd),
		.data_rs(data_rs),
		.data_rt(data_rt),
		.imm(imm),
		.next_pc(next_pc),
		.forward_a(forward_a),
		.forward_b(forward_b),
		.ex_mem_data(out_alu_res), // Result loops back for back-to-back dependents
		.mem_wb_data(mem_wb_data),
		.out_mem_write_enable(out_mem_write_enable),
		.out_wb_res_mux(out_wb_res_mux),
		.out_reg_write_enable(out_reg_write_enable),
		.out_imm(out_imm),
		.out_next_pc(out_next_pc),
		.out_branch_addr(out_branch_addr),
		.out_alu_res(out_alu_res),
		.out_mem_addr(out_mem_addr),
		.out_mem_data(out_mem_data),
		.out_reg_dest(out_reg_dest),
		.branch_taken(branch_taken)
	);

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage #(
	parameter int data_width = 32,
	parameter int pc_width = 16
) (
	input  logic                    clk,
	input  logic                    rst,
	input  ex_ctrl_pkg::alu_funct_t alu_funct,
	input  logic                    alu_src,          // Register or immediate second operand
	input  ex_ctrl_pkg::reg_dst_t   reg_dst,
	input  logic                    fl_write_enable,
	input  logic                    mem_write_enable,
	input  logic                    is_branch,
	input  logic                    sel_jflag_branch,
	input  logic                    sel_beq_bne,
	input  logic                    sel_jt_jf,
	input  logic [1:0]              wb_res_mux,       // Carried to write-back untouched
	input  logic                    reg_write_enable,
	input  core_pkg::reg_addr_t     rs,
	input  core_pkg::reg_addr_t     rt,
	input  core_pkg::reg_addr_t     rd,
	input  logic [data_width-1:0]   data_rs,
	input  logic [data_width-1:0]   data_rt,
	input  logic [data_width-1:0]   imm,
	input  logic [pc_width-1:0]     next_pc,
	input  ex_ctrl_pkg::fwd_sel_t   forward_a,
	input  ex_ctrl_pkg::fwd_sel_t   forward_b,
	input  logic [data_width-1:0]   ex_mem_data,
	input  logic [data_width-1:0]   mem_wb_data,
	output logic                    out_mem_write_enable,
	output logic [1:0]              out_wb_res_mux,
	output logic                    out_reg_write_enable,
	output logic [data_width-1:0]   out_imm,
	output logic [pc_width-1:0]     out_next_pc,
	output logic [pc_width-1:0]     out_branch_addr,
	output logic [data_width-1:0]   out_alu_res,
	output logic [data_width-1:0]   out_mem_addr,
	output logic [data_width-1:0]   out_mem_data,
	output core_pkg::reg_addr_t     out_reg_dest,
	output logic                    branch_taken
);

	logic [data_width-1:0] op_a; // Also the memory address
	logic [data_width-1:0] rt_val; // Forwarded rt, also the store data
	logic [data_width-1:0] op_b;
	logic [data_width-1:0] alu_result;
	logic [ex_ctrl_pkg::flag_width-1:0] alu_flags;
	logic [ex_ctrl_pkg::flag_width-1:0] flags_q;
	logic taken;
	logic squash;
	core_pkg::reg_addr_t dest;
	logic [pc_width-1:0] target;

	assign squash = branch_taken; // Kill the slot right behind a taken branch

	always_comb begin
		case (forward_a)
			ex_ctrl_pkg::fwd_ex: op_a = ex_mem_data;
			ex_ctrl_pkg::fwd_mem: op_a = mem_wb_data;
			default: op_a = data_rs;
		endcase
		case (forward_b)
			ex_ctrl_pkg::fwd_ex: rt_val = ex_mem_data;
			ex_ctrl_pkg::fwd_mem: rt_val = mem_wb_data;
			default: rt_val = data_rt;
		endcase
	end

	assign op_b = (alu_src == ex_ctrl_pkg::alu_src_imm) ? imm : rt_val; // Immediate at the ALU only

	always_comb begin
		case (reg_dst)
			ex_ctrl_pkg::dst_rd: dest = rd;
			ex_ctrl_pkg::dst_rt: dest = rt;
			ex_ctrl_pkg::dst_link: dest = core_pkg::link_reg;
			default: dest = core_pkg::zero_reg;
		endcase
	end

	assign target = next_pc + imm[pc_width-1:0]; // PC-relative, wraps at pc_width

	alu #(
		.data_width(data_width)
	) u_alu (
		.op1(op_a),
		.op2(op_b),
		.funct(alu_funct),
		.result(alu_result),
		.flags(alu_flags)
	);

	flag_reg u_flags (
		.clk(clk),
		.rst(rst),
		.write_enable(fl_write_enable),
		.squash(squash),
		.flags_in(alu_flags),
		.flags(flags_q)
	);

	// Branch sees flags of the last live flag writer, not this instruction's own
	branch_unit u_bru (
		.is_branch(is_branch),
		.sel_jflag_branch(sel_jflag_branch),
		.sel_beq_bne(sel_beq_bne),
		.sel_jt_jf(sel_jt_jf),
		.flag_code(rs),
		.flags(flags_q),
		.taken(taken)
	);

	// EX/MEM pipeline register
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_mem_write_enable <= 1'b0;
			out_wb_res_mux <= '0;
			out_reg_write_enable <= 1'b0;
			out_imm <= '0;
			out_next_pc <= '0;
			out_branch_addr <= '0;
			out_alu_res <= '0;
			out_mem_addr <= '0;
			out_mem_data <= '0;
			out_reg_dest <= '0;
			branch_taken <= 1'b0;
		end else if (squash) begin
			out_mem_write_enable <= 1'b0; // Bubble
			out_wb_res_mux <= '0;
			out_reg_write_enable <= 1'b0;
			out_imm <= '0;
			out_next_pc <= '0;
			out_branch_addr <= '0;
			out_alu_res <= '0;
			out_mem_addr <= '0;
			out_mem_data <= '0;
			out_reg_dest <= '0;
			branch_taken <= 1'b0; // A squashed branch cannot fire
		end else begin
			out_mem_write_enable <= mem_write_enable;
			out_wb_res_mux <= wb_res_mux;
			out_reg_write_enable <= reg_write_enable;
			out_imm <= imm;
			out_next_pc <= next_pc;
			out_branch_addr <= target;
			out_alu_res <= alu_result;
			out_mem_addr <= op_a;
			out_mem_data <= rt_val;
			out_reg_dest <= dest;
			branch_taken <= taken;
		end
	end

	// The slot behind a taken branch must leave no side effects in MEM or WB
	a_squash_no_write: assert property (
		@(posedge clk) disable iff (rst)
		branch_taken |=> (!out_reg_write_enable && !out_mem_write_enable)
	) else $error("instruction behind a taken branch was not squashed");

endmodule

/* src/forward_unit.sv */
`timescale 1ns/1ps

module forward_unit (
	input  core_pkg::reg_addr_t   rs,
	input  core_pkg::reg_addr_t   rt,
	input  core_pkg::reg_addr_t   ex_mem_dest,
	input  logic                  ex_mem_write,
	input  core_pkg::reg_addr_t   mem_wb_dest,
	input  logic                  mem_wb_write,
	output ex_ctrl_pkg::fwd_sel_t forward_a,
	output ex_ctrl_pkg::fwd_sel_t forward_b
);

	// Younger producer in EX/MEM has priority over MEM/WB
	function automatic ex_ctrl_pkg::fwd_sel_t pick(input core_pkg::reg_addr_t src);
		ex_ctrl_pkg::fwd_sel_t sel;
		sel = ex_ctrl_pkg::fwd_none;
		if (src != core_pkg::zero_reg) begin
			if (ex_mem_write && (ex_mem_dest == src)) begin
				sel = ex_ctrl_pkg::fwd_ex;
			end else if (mem_wb_write && (mem_wb_dest == src)) begin
				sel = ex_ctrl_pkg::fwd_mem;
			end
		end
		return sel;
	endfunction

	assign forward_a = pick(rs);
	assign forward_b = pick(rt);

endmodule

/* src/branch_unit.sv */
`timescale 1ns/1ps

// sel_jflag_branch  0 = compare branch, 1 = flag jump
// sel_beq_bne       0 = beq, 1 = bne
// sel_jt_jf         0 = jt, 1 = jf
module branch_unit (
	input  logic                               is_branch,
	input  logic                               sel_jflag_branch,
	input  logic                               sel_beq_bne,
	input  logic                               sel_jt_jf,
	input  core_pkg::reg_addr_t                flag_code, // rs field picks the flag
	input  logic [ex_ctrl_pkg::flag_width-1:0] flags,
	output logic                               taken
);

	logic cmp_taken;
	logic flag_valid; // Codes past the flag vector never jump
	logic flag_bit;
	logic jmp_taken;

	// beq on zero set, bne on zero clear
	assign cmp_taken = sel_beq_bne ? !flags[ex_ctrl_pkg::flag_zero] : flags[ex_ctrl_pkg::flag_zero];

	assign flag_valid = (flag_code < core_pkg::reg_addr_t'(ex_ctrl_pkg::flag_width));

	always_comb begin
		flag_bit = 1'b0;
		if (flag_valid) begin
			flag_bit = flags[flag_code[2:0]];
		end
	end

	// jt on bit set, jf on bit clear
	assign jmp_taken = flag_valid && (sel_jt_jf ? !flag_bit : flag_bit);

	assign taken = is_branch && (sel_jflag_branch ? jmp_taken : cmp_taken);

endmodule

/* src/flag_reg.sv */
`timescale 1ns/1ps

module flag_reg (
	input  logic                               clk,
	input  logic                               rst,
	input  logic                               write_enable,
	input  logic                               squash,
	input  logic [ex_ctrl_pkg::flag_width-1:0] flags_in,
	output logic [ex_ctrl_pkg::flag_width-1:0] flags
);

	logic load; // Only live flag-setting instructions update

	assign load = write_enable && !squash;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			flags <= '0;
		end else if (load) begin
			flags <= flags_in;
		end
	end

	// A loaded value always carries the true bit, only reset leaves it clear
	a_true_when_written: assert property (
		@(posedge clk) disable iff (rst)
		(flags != '0) |-> flags[ex_ctrl_pkg::flag_true]
	) else $error("flag register holds a value without the true bit");

endmodule

/* src/alu.sv */
`timescale 1ns/1ps

module alu #(
	parameter int data_width = 32
) (
	input  logic [data_width-1:0]              op1,
	input  logic [data_width-1:0]              op2,
	input  ex_ctrl_pkg::alu_funct_t            funct,
	output logic [data_width-1:0]              result,
	output logic [ex_ctrl_pkg::flag_width-1:0] flags
);

	localparam int sh_w = $clog2(data_width); // Bits of op2 used as shift amount
	localparam int msb = data_width - 1;

	logic [data_width:0] wide; // Result with the carry bit on top
	logic carry;
	logic ovf;

	always_comb begin
		case (funct)
			ex_ctrl_pkg::alu_add: wide = {1'b0, op1} + {1'b0, op2};
			ex_ctrl_pkg::alu_sub: wide = {1'b0, op1} - {1'b0, op2}; // Top bit is the borrow
			ex_ctrl_pkg::alu_and: wide = {1'b0, op1 & op2};
			ex_ctrl_pkg::alu_or: wide = {1'b0, op1 | op2};
			ex_ctrl_pkg::alu_xor: wide = {1'b0, op1 ^ op2};
			ex_ctrl_pkg::alu_nor: wide = {1'b0, ~(op1 | op2)};
			ex_ctrl_pkg::alu_sll: wide = {1'b0, op1 << op2[sh_w-1:0]};
			ex_ctrl_pkg::alu_srl: wide = {1'b0, op1 >> op2[sh_w-1:0]};
			ex_ctrl_pkg::alu_slt: wide = {{data_width{1'b0}}, $signed(op1) < $signed(op2)};
			ex_ctrl_pkg::alu_pass_b: wide = {1'b0, op2};
			default: wide = '0; // Unknown function gives zero
		endcase
	end

	// Carry and overflow only mean something for the adder
	always_comb begin
		carry = 1'b0;
		ovf = 1'b0;
		if (funct == ex_ctrl_pkg::alu_add) begin
			carry = wide[data_width];
			ovf = (op1[msb] == op2[msb]) && (wide[msb] != op1[msb]); // Same signs in, other out
		end else if (funct == ex_ctrl_pkg::alu_sub) begin
			carry = wide[data_width];
			ovf = (op1[msb] != op2[msb]) && (wide[msb] != op1[msb]);
		end
	end

	assign result = wide[data_width-1:0];

	always_comb begin
		flags = '0;
		flags[ex_ctrl_pkg::flag_zero] = (result == '0);
		flags[ex_ctrl_pkg::flag_neg] = result[msb];
		flags[ex_ctrl_pkg::flag_carry] = carry;
		flags[ex_ctrl_pkg::flag_ovf] = ovf;
		flags[ex_ctrl_pkg::flag_true] = 1'b1; // Lets jt on code 4 act as an unconditional jump
	end

endmodule

/* src/ex_ctrl_pkg.sv */
// Control encodings decoded upstream and consumed by the execute stage
package ex_ctrl_pkg;

	// ALU function select
	typedef logic [5:0] alu_funct_t;

	localparam alu_funct_t alu_add = 6'd0;
	localparam alu_funct_t alu_sub = 6'd1;
	localparam alu_funct_t alu_and = 6'd2;
	localparam alu_funct_t alu_or = 6'd3;
	localparam alu_funct_t alu_xor = 6'd4;
	localparam alu_funct_t alu_nor = 6'd5;
	localparam alu_funct_t alu_sll = 6'd6; // Shift left by op2 low bits
	localparam alu_funct_t alu_srl = 6'd7; // Logical shift right
	localparam alu_funct_t alu_slt = 6'd8; // Signed set-less-than
	localparam alu_funct_t alu_pass_b = 6'd9; // Result is op2 (load immediate)

	// Operand forward select
	typedef logic [1:0] fwd_sel_t;

	localparam fwd_sel_t fwd_none = 2'd0; // Register file value
	localparam fwd_sel_t fwd_ex = 2'd1; // Result sitting in EX/MEM
	localparam fwd_sel_t fwd_mem = 2'd2; // Value being written back

	// Destination register select
	typedef logic [1:0] reg_dst_t;

	localparam reg_dst_t dst_rd = 2'd0;
	localparam reg_dst_t dst_rt = 2'd1;
	localparam reg_dst_t dst_link = 2'd2;
	// Code 3 is unused and picks register 0

	// Second ALU operand select
	localparam logic alu_src_reg = 1'b0;
	localparam logic alu_src_imm = 1'b1;

	// Flag vector layout
	localparam int unsigned flag_width = 5;

	localparam int unsigned flag_zero = 0;
	localparam int unsigned flag_neg = 1;
	localparam int unsigned flag_carry = 2; // Borrow on sub
	localparam int unsigned flag_ovf = 3;
	localparam int unsigned flag_true = 4; // Set on every flag write

endpackage

/* src/core_pkg.sv */
// Datapath sizes shared by the execute stage and its neighbours
package core_pkg;

	// Default data word width, overridable at the top level
	localparam int unsigned gpr_width = 32;

	// Default instruction address width
	localparam int unsigned pc_width = 16;

	// 16 general purpose registers
	localparam int unsigned reg_addr_width = 4;
	localparam int unsigned reg_count = 1 << reg_addr_width;

	// Register address as carried through the pipe
	typedef logic [reg_addr_width-1:0] reg_addr_t;

	// Register 0 reads as zero and is never a forwarding source
	localparam reg_addr_t zero_reg = reg_addr_t'(0);

	// Jump-and-link writes the return address here
	localparam reg_addr_t link_reg = reg_addr_t'(reg_count - 1);

endpackage
